//--- apb2axi_stimulus.txt
# op addr data resp : op W or R, addr and data in hex, resp 0 OKAY or 2 SLVERR
# for R lines the data column is the word expected back from the slave memory
W 00000100 deadbeef 0
W 00000104 12345678 0
R 00000100 deadbeef 0
R 00000104 12345678 0
R 00000108 00000000 0
W 00000100 cafef00d 0
R 00000100 cafef00d 0
W 80000010 0badf00d 2
R 80000010 00000000 2
W 0000fffc a5a55a5a 0
R 0000fffc a5a55a5a 0
R 80000000 00000000 2
W 00000010 00000001 0
R 00000010 00000001 0

//--- apb2axi.f
+incdir+.
axi_pkg.sv
bridge_pkg.sv
apb_req_regs.sv
req_fifo.sv
axi_single_master.sv
apb2axi.sv
apb2axi_assert.sv
apb2axi_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the APB to AXI3 bridge

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		-f apb2axi.f --top-module apb2axi_tb

run: build
	@out=$$(./obj_dir/Vapb2axi_tb +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -Wall \
		-f apb2axi.f --top-module apb2axi_tb

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- apb2axi_tb.sv
// Testbench for the APB to AXI3 bridge, run from the stimulus file with a random-delay AXI slave
`default_nettype none
`timescale 1ns/10ps

`include "bridge_defs.svh"

module apb2axi_tb;

  logic        pclk = 1'b0;
  logic        arst_n = 1'b0;
  logic [31:0] paddr = '0;
  logic [31:0] pwdata = '0;
  logic        pwrite = 1'b0;
  logic        psel = 1'b0;
  logic        penable = 1'b0;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [31:0] awaddr;
  logic [3:0]  awlen;
  logic [2:0]  awsize;
  logic [1:0]  awburst;
  logic        awvalid;
  logic        awready = 1'b0;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wlast;
  logic        wvalid;
  logic        wready = 1'b0;
  logic [1:0]  bresp = 2'b00;
  logic        bvalid = 1'b0;
  logic        bready;
  logic [31:0] araddr;
  logic [3:0]  arlen;
  logic [2:0]  arsize;
  logic [1:0]  arburst;
  logic        arvalid;
  logic        arready = 1'b0;
  logic [31:0] rdata = '0;
  logic [1:0]  rresp = 2'b00;
  logic        rlast = 1'b0;
  logic        rvalid = 1'b0;
  logic        rready;

  // Slave model state
  logic        stall = 1'b0;
  logic        aw_seen = 1'b0;
  logic        w_seen = 1'b0;
  logic        ar_seen = 1'b0;
  logic [31:0] got_addr = '0;
  logic [31:0] got_wdata = '0;
  logic [31:0] got_raddr = '0;
  int          addr_dly = 0;
  int          w_dly = 0;
  int          resp_dly = 0;
  logic [31:0] slave_mem [logic [31:0]];
  logic [31:0] addr_log [$];

  // Expected side
  logic [31:0] ref_mem [logic [31:0]];
  logic [7:0]  cpl_total = 8'd0;

  apb2axi apb2axi_inst (.*);

  initial begin
    forever #2 pclk = ~pclk;
  end

  task automatic report_mismatch(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "wrong value from the bridge");
  endtask

  task automatic abort_run(input string msg);
    $display("Run stopped: %s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  // Bound protocol checks end the run at their first failure
  always @(negedge pclk) begin
    if (apb2axi_inst.assert_inst.fail_cnt != 0) begin
      abort_run("a bound AXI or APB protocol assertion failed");
    end
  end

  // ========================================
  // APB master
  // ========================================
  task automatic apb_xfer(input logic wr, input logic [7:0] off, input logic [31:0] data,
                          output logic [31:0] rd, output logic err);
    int n;
    @(posedge pclk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= wr;
    paddr <= {24'd0, off};
    pwdata <= data;
    @(posedge pclk);
    penable <= 1'b1;
    n = 0;
    do begin
      @(negedge pclk);
      n++;
    end while (!pready && n < 16);
    if (!pready) abort_run("pready never came in the APB access phase");
    rd = prdata;
    err = pslverr;
    @(posedge pclk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  // Polls STATUS until the completion count reaches the target
  task automatic wait_count(input logic [7:0] target);
    logic [31:0] st;
    logic        err;
    int          n;
    n = 0;
    do begin
      apb_xfer(1'b0, `REG_STATUS, 32'd0, st, err);
      n++;
    end while (st[15:8] != target && n < 200);
    if (st[15:8] != target) abort_run("completion count never reached its target");
  endtask

  // ========================================
  // AXI slave model
  // ========================================
  initial begin
    void'($urandom(32'h7e759681));
    forever begin
      @(posedge pclk);
      if (!arst_n) begin
        awready <= 1'b0;
        wready <= 1'b0;
        arready <= 1'b0;
        bvalid <= 1'b0;
        rvalid <= 1'b0;
        aw_seen <= 1'b0;
        w_seen <= 1'b0;
        ar_seen <= 1'b0;
      end else begin
        // AW and AR share one delay since the bridge never issues both
        if (awvalid && awready) begin
          awready <= 1'b0;
          aw_seen <= 1'b1;
          got_addr <= awaddr;
          addr_log.push_back(awaddr);
          addr_dly <= $urandom % 4;
          assert (awlen == 4'd0 && awsize == 3'd2 && awburst == 2'b01)
            else report_mismatch($sformatf("AW len %0d size %0d burst %0d",
                                           awlen, awsize, awburst));
        end else if (arvalid && arready) begin
          arready <= 1'b0;
          ar_seen <= 1'b1;
          got_raddr <= araddr;
          addr_log.push_back(araddr);
          addr_dly <= $urandom % 4;
          assert (arlen == 4'd0 && arsize == 3'd2 && arburst == 2'b01)
            else report_mismatch($sformatf("AR len %0d size %0d burst %0d",
                                           arlen, arsize, arburst));
        end else if ((awvalid || arvalid) && !stall) begin
          if (addr_dly == 0) begin
            awready <= awvalid;
            arready <= arvalid;
          end else begin
            addr_dly <= addr_dly - 1;
          end
        end
        if (wvalid && wready) begin
          wready <= 1'b0;
          w_seen <= 1'b1;
          got_wdata <= wdata;
          w_dly <= $urandom % 4;
          assert (wstrb == 4'hf && wlast)
            else report_mismatch($sformatf("W strobe %h last %b", wstrb, wlast));
        end else if (wvalid && !stall) begin
          if (w_dly == 0) wready <= 1'b1;
          else w_dly <= w_dly - 1;
        end
        // Responses with SLVERR for the upper half of the address space
        if (bvalid && bready) begin
          bvalid <= 1'b0;
          aw_seen <= 1'b0;
          w_seen <= 1'b0;
          resp_dly <= $urandom % 4;
        end else if (rvalid && rready) begin
          rvalid <= 1'b0;
          ar_seen <= 1'b0;
          resp_dly <= $urandom % 4;
        end else if (!bvalid && !rvalid && ((aw_seen && w_seen) || ar_seen)) begin
          if (resp_dly != 0) begin
            resp_dly <= resp_dly - 1;
          end else if (ar_seen) begin
            rvalid <= 1'b1;
            rlast <= 1'b1;
            rresp <= got_raddr[31] ? 2'b10 : 2'b00;
            rdata <= slave_mem.exists(got_raddr) ? slave_mem[got_raddr] : 32'd0;
          end else begin
            bvalid <= 1'b1;
            bresp <= got_addr[31] ? 2'b10 : 2'b00;
            if (!got_addr[31]) slave_mem[got_addr] = got_wdata;
          end
        end
      end
    end
  end

  // ========================================
  // Stimulus file commands
  // ========================================
  task automatic run_file();
    int          fd;
    int          n;
    int          resp_i;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    logic [31:0] exp_rd;
    logic        err;
    fd = $fopen("apb2axi_stimulus.txt", "r");
    if (fd == 0) abort_run("cannot open apb2axi_stimulus.txt");
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%c %h %h %d", op, addr, data, resp_i);
      if (n != 4) abort_run("malformed line in the stimulus file");
      apb_xfer(1'b1, `REG_ADDR, addr, rd, err);
      apb_xfer(1'b1, `REG_WDATA, data, rd, err);
      apb_xfer(1'b1, `REG_CMD, {31'd0, op == "W"}, rd, err);
      assert (!err) else report_mismatch($sformatf("CMD for %h refused", addr));
      cpl_total = cpl_total + 8'd1;
      wait_count(cpl_total);
      apb_xfer(1'b0, `REG_RESP, 32'd0, rd, err);
      assert (rd[1:0] == resp_i[1:0])
        else report_mismatch($sformatf("RESP %0d for %h, expected %0d", rd[1:0], addr, resp_i));
      if (op == "W") begin
        assert (got_addr == addr && got_wdata == data)
          else report_mismatch($sformatf("AW/W saw %h/%h, expected %h/%h",
                                         got_addr, got_wdata, addr, data));
        if (!addr[31]) ref_mem[addr] = data;
      end else begin
        assert (got_raddr == addr)
          else report_mismatch($sformatf("AR saw %h, expected %h", got_raddr, addr));
        exp_rd = ref_mem.exists(addr) ? ref_mem[addr] : 32'd0;
        apb_xfer(1'b0, `REG_RDATA, 32'd0, rd, err);
        assert (rd == exp_rd && rd == data)
          else report_mismatch($sformatf("RDATA %h for %h, expected %h", rd, addr, exp_rd));
      end
    end
    $fclose(fd);
  endtask

  // ========================================
  // Back-pressure with the slave stalled
  // ========================================
  task automatic stall_test();
    logic [31:0] sent [$];
    logic [31:0] a;
    logic [31:0] rd;
    logic        err;
    int          accepted;
    stall <= 1'b1;
    addr_log.delete();
    accepted = 0;
    err = 1'b0;
    while (!err && accepted < 8) begin
      a = 32'h0000_0200 + accepted * 4;
      apb_xfer(1'b1, `REG_ADDR, a, rd, err);
      apb_xfer(1'b1, `REG_WDATA, ~a, rd, err);
      apb_xfer(1'b1, `REG_CMD, 32'd1, rd, err);
      if (!err) begin
        sent.push_back(a);
        accepted++;
      end
    end
    // One request sits in the master and the rest fill the FIFO
    assert (accepted == `BRIDGE_FIFO_DEPTH + 1)
      else report_mismatch($sformatf("%0d commands accepted while stalled", accepted));
    apb_xfer(1'b0, `REG_STATUS, 32'd0, rd, err);
    assert (rd[0] && rd[15:8] == cpl_total)
      else report_mismatch($sformatf("STATUS %h while stalled", rd));
    stall <= 1'b0;
    cpl_total = cpl_total + 8'(accepted);
    wait_count(cpl_total);
    assert (addr_log.size() == sent.size())
      else report_mismatch($sformatf("%0d AXI transfers after release", addr_log.size()));
    foreach (sent[i]) begin
      assert (addr_log[i] == sent[i])
        else report_mismatch($sformatf("transfer %0d at %h, expected %h",
                                       i, addr_log[i], sent[i]));
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    repeat (4) @(posedge pclk);
    arst_n <= 1'b1;
    @(posedge pclk);
    @(negedge pclk);
    assert (!awvalid && !wvalid && !arvalid && !bready && !rready && !pslverr && pready)
      else report_mismatch("bridge AXI or APB outputs not idle after reset");
    apb_xfer(1'b0, `REG_STATUS, 32'd0, rd, err);
    assert (rd == 32'd0 && !err) else report_mismatch($sformatf("STATUS %h after reset", rd));
    run_file();
    stall_test();
    apb_xfer(1'b1, 8'h18, 32'd0, rd, err);
    assert (err) else report_mismatch("no pslverr on write to offset 0x18");
    apb_xfer(1'b0, 8'h1C, 32'd0, rd, err);
    assert (err) else report_mismatch("no pslverr on read from offset 0x1C");
    if (apb2axi_inst.assert_inst.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("SOME TESTS FAILED");
      $fatal(1, "bound protocol assertions failed");
    end
  end

endmodule

`default_nettype wire

//--- apb2axi_assert.sv
// Concurrent protocol checks bound into the bridge top level for AXI valid rules and APB errors
`default_nettype none
`timescale 1ns/10ps

module apb2axi_assert (
  input logic pclk,
  input logic arst_n,
  input logic awvalid,
  input logic awready,
  input logic arvalid,
  input logic arready,
  input logic psel,
  input logic penable,
  input logic pslverr
);

  int fail_cnt = 0;

  // ========================================
  // AXI address channels
  // ========================================
  aw_hold: assert property (@(posedge pclk) disable iff (!arst_n)
                            awvalid && !awready |=> awvalid)
    else begin
      $error("awvalid dropped before awready");
      fail_cnt++;
    end

  ar_hold: assert property (@(posedge pclk) disable iff (!arst_n)
                            arvalid && !arready |=> arvalid)
    else begin
      $error("arvalid dropped before arready");
      fail_cnt++;
    end

  // Only one request on AXI at a time
  aw_ar_excl: assert property (@(posedge pclk) disable iff (!arst_n) !(awvalid && arvalid))
    else begin
      $error("awvalid and arvalid high together");
      fail_cnt++;
    end

  slverr_access: assert property (@(posedge pclk) disable iff (!arst_n)
                                  pslverr |-> psel && penable)
    else begin
      $error("pslverr outside an APB access phase");
      fail_cnt++;
    end

endmodule

bind apb2axi apb2axi_assert assert_inst (
  .pclk(pclk), .arst_n(arst_n),
  .awvalid(awvalid), .awready(awready), .arvalid(arvalid), .arready(arready),
  .psel(psel), .penable(penable), .pslverr(pslverr)
);

`default_nettype wire

//--- apb2axi.sv
// Top level of the APB to AXI3 bridge, connecting register file, request FIFO and AXI master
`default_nettype none
`timescale 1ns/10ps

`include "bridge_defs.svh"

module apb2axi (
  input  logic                        pclk,
  input  logic                        arst_n,
  // APB slave
  input  logic [`BRIDGE_ADDR_W-1:0]   paddr,
  input  logic [`BRIDGE_DATA_W-1:0]   pwdata,
  input  logic                        pwrite,
  input  logic                        psel,
  input  logic                        penable,
  output logic [`BRIDGE_DATA_W-1:0]   prdata,
  output logic                        pready,
  output logic                        pslverr,
  // AXI3 write address and data
  output logic [`BRIDGE_ADDR_W-1:0]   awaddr,
  output logic [3:0]                  awlen,
  output logic [2:0]                  awsize,
  output logic [1:0]                  awburst,
  output logic                        awvalid,
  input  logic                        awready,
  output logic [`BRIDGE_DATA_W-1:0]   wdata,
  output logic [`BRIDGE_DATA_W/8-1:0] wstrb,
  output logic                        wlast,
  output logic                        wvalid,
  input  logic                        wready,
  input  logic [1:0]                  bresp,
  input  logic                        bvalid,
  output logic                        bready,
  // AXI3 read
  output logic [`BRIDGE_ADDR_W-1:0]   araddr,
  output logic [3:0]                  arlen,
  output logic [2:0]                  arsize,
  output logic [1:0]                  arburst,
  output logic                        arvalid,
  input  logic                        arready,
  input  logic [`BRIDGE_DATA_W-1:0]   rdata,
  input  logic [1:0]                  rresp,
  input  logic                        rlast,
  input  logic                        rvalid,
  output logic                        rready
);

  logic                     push, pop, full, empty, cpl_valid;
  bridge_pkg::bridge_req_t  push_req, head;
  bridge_pkg::bridge_cpl_t  cpl;
  axi_pkg::axi_addr_chan_t  aw_chan, ar_chan;
  axi_pkg::axi_wdata_chan_t w_chan;

  apb_req_regs u_regs (
    .pclk(pclk), .arst_n(arst_n),
    .paddr(paddr), .pwdata(pwdata), .pwrite(pwrite), .psel(psel), .penable(penable),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .full(full), .push(push), .push_req(push_req),
    .cpl_valid(cpl_valid), .cpl(cpl)
  );

  req_fifo u_fifo (
    .pclk(pclk), .arst_n(arst_n),
    .push(push), .push_req(push_req), .pop(pop),
    .head(head), .full(full), .empty(empty)
  );

  axi_single_master u_master (
    .pclk(pclk), .arst_n(arst_n),
    .empty(empty), .head(head), .pop(pop),
    .aw(aw_chan), .awvalid(awvalid), .awready(awready),
    .w(w_chan), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .ar(ar_chan), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
    .cpl_valid(cpl_valid), .cpl(cpl)
  );

  // Flat AXI port names
  assign awaddr  = aw_chan.addr;
  assign awlen   = aw_chan.len;
  assign awsize  = aw_chan.size;
  assign awburst = aw_chan.burst;
  assign wdata   = w_chan.data;
  assign wstrb   = w_chan.strb;
  assign wlast   = w_chan.last;
  assign araddr  = ar_chan.addr;
  assign arlen   = ar_chan.len;
  assign arsize  = ar_chan.size;
  assign arburst = ar_chan.burst;

endmodule

`default_nettype wire

//--- axi_single_master.sv
// AXI3 master that issues one single-beat read or write per queued request and reports completion
`default_nettype none
`timescale 1ns/10ps

`include "bridge_defs.svh"

module axi_single_master (
  input  logic                        pclk,
  input  logic                        arst_n,
  input  logic                        empty,
  input  bridge_pkg::bridge_req_t     head,
  output logic                        pop,
  output axi_pkg::axi_addr_chan_t     aw,
  output logic                        awvalid,
  input  logic                        awready,
  output axi_pkg::axi_wdata_chan_t    w,
  output logic                        wvalid,
  input  logic                        wready,
  input  logic [1:0]                  bresp,
  input  logic                        bvalid,
  output logic                        bready,
  output axi_pkg::axi_addr_chan_t     ar,
  output logic                        arvalid,
  input  logic                        arready,
  input  logic [`BRIDGE_DATA_W-1:0]   rdata,
  input  logic [1:0]                  rresp,
  input  logic                        rlast,
  input  logic                        rvalid,
  output logic                        rready,
  output logic                        cpl_valid,
  output bridge_pkg::bridge_cpl_t     cpl
);

  bridge_pkg::master_state_e state;
  bridge_pkg::bridge_req_t   req_q;
  logic                      aw_pend, w_pend, ar_pend;
  logic                      aw_left, w_left, ar_left;
  logic                      is_write;
  logic                      resp_hit;

  assign is_write = (req_q.op == bridge_pkg::OP_WRITE);
  assign pop      = (state == bridge_pkg::IDLE) & ~empty;

  // Valids still waiting after this cycle
  assign aw_left = aw_pend & ~awready;
  assign w_left  = w_pend & ~wready;
  assign ar_left = ar_pend & ~arready;

  // ========================================
  // Sequencing
  // ========================================
  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= bridge_pkg::IDLE;
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
      ar_pend <= 1'b0;
    end else begin
      case (state)
        bridge_pkg::IDLE: begin
          if (!empty) begin
            state   <= bridge_pkg::ISSUE;
            aw_pend <= (head.op == bridge_pkg::OP_WRITE);
            w_pend  <= (head.op == bridge_pkg::OP_WRITE);
            ar_pend <= (head.op == bridge_pkg::OP_READ);
          end
        end
        bridge_pkg::ISSUE: begin
          aw_pend <= aw_left;
          w_pend  <= w_left;
          ar_pend <= ar_left;
          // AW and W may be accepted in either order
          if (!(aw_left || w_left || ar_left)) state <= bridge_pkg::WAIT_RESP;
        end
        bridge_pkg::WAIT_RESP: begin
          if (resp_hit) state <= bridge_pkg::IDLE;
        end
        default: state <= bridge_pkg::IDLE;
      endcase
    end
  end

  // Popped request
  always_ff @(posedge pclk) begin
    if (pop) req_q <= head;
  end

  // ========================================
  // Channel drive and response
  // ========================================
  assign aw.addr  = req_q.addr;
  assign aw.len   = `AXI_LEN_SINGLE;
  assign aw.size  = `AXI_SIZE_WORD;
  assign aw.burst = axi_pkg::BURST_INCR;
  assign ar       = aw;

  assign w.data = req_q.wdata;
  assign w.strb = '1;
  assign w.last = 1'b1;

  assign awvalid = aw_pend;
  assign wvalid  = w_pend;
  assign arvalid = ar_pend;

  assign bready   = (state == bridge_pkg::WAIT_RESP) & is_write;
  assign rready   = (state == bridge_pkg::WAIT_RESP) & ~is_write;
  assign resp_hit = (bready & bvalid) | (rready & rvalid);

  assign cpl_valid = resp_hit;

  always_comb begin
    cpl.op = req_q.op;
    if (is_write) begin
      cpl.resp  = axi_pkg::axi_resp_e'(bresp);
      cpl.rdata = '0;
    end else begin
      // A single-beat read without rlast is a protocol error
      cpl.resp  = rlast ? axi_pkg::axi_resp_e'(rresp) : axi_pkg::RESP_SLVERR;
      cpl.rdata = rdata;
    end
  end

endmodule

`default_nettype wire

//--- req_fifo.sv
// Synchronous request FIFO that keeps APB commands in order until the AXI master takes them
`default_nettype none
`timescale 1ns/10ps

`include "bridge_defs.svh"

module req_fifo (
  input  logic                    pclk,
  input  logic                    arst_n,
  input  logic                    push,
  input  bridge_pkg::bridge_req_t push_req,
  input  logic                    pop,
  output bridge_pkg::bridge_req_t head,
  output logic                    full,
  output logic                    empty
);

  localparam int PTR_W = $clog2(`BRIDGE_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`BRIDGE_FIFO_DEPTH + 1);

  bridge_pkg::bridge_req_t mem [`BRIDGE_FIFO_DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [CNT_W-1:0]        count;

  // Wrap at the last slot since depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(`BRIDGE_FIFO_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_next(wr_ptr);
      if (pop)  rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge pclk) begin
    if (push) mem[wr_ptr] <= push_req;
  end

  assign head  = mem[rd_ptr];
  assign full  = (count == CNT_W'(`BRIDGE_FIFO_DEPTH));
  assign empty = (count == '0);

endmodule

`default_nettype wire

//--- apb_req_regs.sv
// APB slave register file that turns CMD writes into queued requests and records completions
`default_nettype none
`timescale 1ns/10ps

`include "bridge_defs.svh"

module apb_req_regs (
  input  logic                        pclk,
  input  logic                        arst_n,
  input  logic [`BRIDGE_ADDR_W-1:0]   paddr,
  input  logic [`BRIDGE_DATA_W-1:0]   pwdata,
  input  logic                        pwrite,
  input  logic                        psel,
  input  logic                        penable,
  output logic [`BRIDGE_DATA_W-1:0]   prdata,
  output logic                        pready,
  output logic                        pslverr,
  input  logic                        full,
  output logic                        push,
  output bridge_pkg::bridge_req_t     push_req,
  input  logic                        cpl_valid,
  input  bridge_pkg::bridge_cpl_t     cpl
);

  logic [`BRIDGE_ADDR_W-1:0] addr_q;
  logic [`BRIDGE_DATA_W-1:0] wdata_q;
  logic [`BRIDGE_DATA_W-1:0] rdata_q;
  axi_pkg::axi_resp_e        resp_q;
  logic [7:0]                cpl_cnt;
  logic                      access;
  logic                      known_reg;
  logic                      cmd_wr;

  // No wait states
  assign pready = 1'b1;
  assign access = psel & penable;

  // ========================================
  // Read mux and offset decode
  // ========================================
  always_comb begin
    known_reg = 1'b1;
    prdata    = '0;
    case (paddr[7:0])
      `REG_ADDR:   prdata = addr_q;
      `REG_WDATA:  prdata = wdata_q;
      `REG_CMD:    prdata = '0;
      `REG_STATUS: prdata = {16'd0, cpl_cnt, 6'd0, full, full};
      `REG_RDATA:  prdata = rdata_q;
      `REG_RESP:   prdata = {{(`BRIDGE_DATA_W-2){1'b0}}, resp_q};
      default:     known_reg = 1'b0;
    endcase
  end

  // ========================================
  // Request build and push
  // ========================================
  assign cmd_wr = access & pwrite & (paddr[7:0] == `REG_CMD);
  // Command dropped when the FIFO has no room
  assign push   = cmd_wr & ~full;

  assign push_req.op    = bridge_pkg::bridge_op_e'(pwdata[0]);
  assign push_req.addr  = addr_q;
  assign push_req.wdata = wdata_q;

  assign pslverr = access & (~known_reg | (cmd_wr & full));

  // Staged address and write data
  always_ff @(posedge pclk) begin
    if (access && pwrite) begin
      if (paddr[7:0] == `REG_ADDR) begin
        addr_q <= pwdata;
      end
      if (paddr[7:0] == `REG_WDATA) begin
        wdata_q <= pwdata;
      end
    end
  end

  // ========================================
  // Completion record
  // ========================================
  always_ff @(posedge pclk or negedge arst_n) begin
    if (!arst_n) begin
      cpl_cnt <= 8'd0;
      rdata_q <= '0;
      resp_q  <= axi_pkg::RESP_OKAY;
    end else if (cpl_valid) begin
      cpl_cnt <= cpl_cnt + 8'd1;
      resp_q  <= cpl.resp;
      // Write completions leave the last read data alone
      if (cpl.op == bridge_pkg::OP_READ) begin
        rdata_q <= cpl.rdata;
      end
    end
  end

endmodule

`default_nettype wire

//--- bridge_pkg.sv
// Bridge-side request, completion and master state types shared by the RTL stages
`default_nettype none

`include "bridge_defs.svh"

package bridge_pkg;

  // Command bit 0 selects the opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bridge_op_e;

  // One queued request
  typedef struct packed {
    bridge_op_e                op;
    logic [`BRIDGE_ADDR_W-1:0] addr;
    logic [`BRIDGE_DATA_W-1:0] wdata;
  } bridge_req_t;

  // One finished AXI transfer
  typedef struct packed {
    bridge_op_e                op;
    axi_pkg::axi_resp_e        resp;
    logic [`BRIDGE_DATA_W-1:0] rdata;
  } bridge_cpl_t;

  // AXI master sequencing
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    ISSUE     = 2'd1,
    WAIT_RESP = 2'd2
  } master_state_e;

endpackage

`default_nettype wire

//--- axi_pkg.sv
// AXI3 channel types shared by the master, the top level and the testbench slave model
`default_nettype none

`include "bridge_defs.svh"

package axi_pkg;

  // Burst type encoding
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  // B and R response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // AW and AR payload
  typedef struct packed {
    logic [`BRIDGE_ADDR_W-1:0] addr;
    logic [3:0]                len;
    logic [2:0]                size;
    axi_burst_e                burst;
  } axi_addr_chan_t;

  // W payload
  typedef struct packed {
    logic [`BRIDGE_DATA_W-1:0]   data;
    logic [`BRIDGE_DATA_W/8-1:0] strb;
    logic                        last;
  } axi_wdata_chan_t;

endpackage

`default_nettype wire

//--- bridge_defs.svh
// Bus widths, request FIFO depth, register map and fixed AXI fields, included by RTL and testbench
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// ========================================
// Bus widths
// ========================================
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// Request slots between the APB and AXI sides
`define BRIDGE_FIFO_DEPTH 4

// ========================================
// APB register byte offsets
// ========================================
`define REG_ADDR   8'h00
`define REG_WDATA  8'h04
`define REG_CMD    8'h08
`define REG_STATUS 8'h0C
`define REG_RDATA  8'h10
`define REG_RESP   8'h14

// Fixed AXI fields for single-beat word transfers
`define AXI_LEN_SINGLE 4'd0
`define AXI_SIZE_WORD  3'd2

`endif
